//--- hw/coreFrontEndPkg.sv
package coreFrontEndPkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and counts
  //////////////////////////////////////////////////////////////////////

  // Data and address width
  localparam int unsigned XLEN = 32;

  // Architectural registers, x0 included
  localparam int unsigned REG_NUM = 32;

  // Index width for REG_NUM registers
  localparam int unsigned REG_IDX_WIDTH = $clog2(REG_NUM);

  // Read ports on the register file
  localparam int unsigned RD_PORT_NUM = 2;

  // In-flight result buses
  localparam int unsigned FWD_PORT_NUM = 2;

  // PC redirect channels, channel 0 wins
  localparam int unsigned SET_PORT_NUM = 3;

  // Step of 2 or 4 fits in 3 bits
  localparam int unsigned STEP_WIDTH = 3;

  //////////////////////////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////////////////////////

  // Data word or PC
  typedef logic [XLEN-1:0] xlenT;

  // Register index
  typedef logic [REG_IDX_WIDTH-1:0] regIdxT;

  // PC increment
  typedef logic [STEP_WIDTH-1:0] pcStepT;

  // PC value out of reset
  localparam xlenT START_ADDR = 32'h8000_0000;

endpackage : coreFrontEndPkg

//--- hw/rfWrBusIf.sv
`timescale 1ns/100ps

interface rfWrBusIf;
  import coreFrontEndPkg::*;

  // Write port, single-cycle strobe
  logic   wrVld;
  regIdxT wrRd;
  xlenT   wrDat;

  // Forwarding buses, one entry per bus
  // Low vld with a matching rd means result still pending
  logic   [FWD_PORT_NUM-1:0] fwdVld;
  regIdxT [FWD_PORT_NUM-1:0] fwdRd;
  xlenT   [FWD_PORT_NUM-1:0] fwdDat;

  // Driver side
  modport source (
    output wrVld, wrRd, wrDat,
    output fwdVld, fwdRd, fwdDat
  );

  // Register file side
  modport sink (
    input wrVld, wrRd, wrDat,
    input fwdVld, fwdRd, fwdDat
  );

endinterface : rfWrBusIf

//--- hw/pcGen.sv
`timescale 1ns/100ps

module pcGen (
  input  logic                                                      clk,
  input  logic                                                      rstN,
  input  logic                                                      stall,
  input  logic                   [coreFrontEndPkg::SET_PORT_NUM-1:0] setEn,
  input  coreFrontEndPkg::xlenT  [coreFrontEndPkg::SET_PORT_NUM-1:0] setPc,
  input  coreFrontEndPkg::pcStepT                                   nxtPcStep,
  output coreFrontEndPkg::xlenT                                     pc,
  output coreFrontEndPkg::xlenT                                     nxtPc
);
  import coreFrontEndPkg::*;

  //////////////////////////////////////////////////////////////////////
  // Settling flag
  //////////////////////////////////////////////////////////////////////

  // Low in reset and in the first cycle after it
  logic rstFlg;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rstFlg <= 1'b0;
    end else if (!rstFlg) begin
      // Sets once, then stays
      rstFlg <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Next PC select
  //////////////////////////////////////////////////////////////////////

  logic [SET_PORT_NUM-1:0] setEnOh;
  xlenT                    prioPc;
  pcStepT                  stepMasked;
  xlenT                    stepPc;
  logic                    stepPcVld;

  // Lowest set bit only, so channel 0 wins
  assign setEnOh = setEn & (~setEn + 1'b1);

  // One-hot AND-OR mux over the set channels
  always_comb begin
    prioPc = '0;
    for (int i = 0; i < SET_PORT_NUM; i++) begin
      prioPc = prioPc | (setPc[i] & {XLEN{setEnOh[i]}});
    end
  end

  // Step forced to zero while settling
  assign stepMasked = nxtPcStep & {STEP_WIDTH{rstFlg}};
  assign stepPc     = pc + xlenT'(stepMasked);

  // Stepped PC when no channel fires, or during settling
  assign stepPcVld = (setEnOh == '0) | ~rstFlg;
  assign nxtPc     = stepPcVld ? stepPc : prioPc;

  //////////////////////////////////////////////////////////////////////
  // PC register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= START_ADDR;
    end else if (!stall) begin
      pc <= nxtPc;
    end
  end

endmodule : pcGen

//--- hw/fwdMux.sv
`timescale 1ns/100ps

module fwdMux (
  input  logic                  [coreFrontEndPkg::FWD_PORT_NUM-1:0] fwdVld,
  input  coreFrontEndPkg::regIdxT [coreFrontEndPkg::FWD_PORT_NUM-1:0] fwdRd,
  input  coreFrontEndPkg::xlenT [coreFrontEndPkg::FWD_PORT_NUM-1:0] fwdDat,
  input  coreFrontEndPkg::regIdxT                                   rs,
  input  coreFrontEndPkg::xlenT                                     rfDat,
  output coreFrontEndPkg::xlenT                                     dat,
  output logic                                                      hazard
);
  import coreFrontEndPkg::*;

  // x0 never forwards and never stalls
  logic rsVld;

  // Bus entries first, stored value as last fallback entry
  logic [FWD_PORT_NUM:0] selBitmap;
  logic [FWD_PORT_NUM:0] selOh;
  xlenT [FWD_PORT_NUM:0] allDat;

  assign rsVld = |rs;

  // Match on rd alone, vld only decides the hazard
  always_comb begin
    for (int i = 0; i < FWD_PORT_NUM; i++) begin
      selBitmap[i] = (fwdRd[i] == rs) & rsVld;
      allDat[i]    = fwdDat[i];
    end
    selBitmap[FWD_PORT_NUM] = rsVld;
    allDat[FWD_PORT_NUM]    = rfDat;
  end

  // Lowest-indexed hit wins
  assign selOh = selBitmap & (~selBitmap + 1'b1);

  // Nothing selected for x0, so dat falls to zero
  always_comb begin
    dat = '0;
    for (int i = 0; i <= FWD_PORT_NUM; i++) begin
      dat = dat | (allDat[i] & {XLEN{selOh[i]}});
    end
  end

  // Selected bus with its result not ready yet
  assign hazard = |(selOh[FWD_PORT_NUM-1:0] & ~fwdVld);

endmodule : fwdMux

//--- hw/regFile.sv
`timescale 1ns/100ps

module regFile (
  input  logic                                                     clk,
  input  logic                                                     rstN,
  rfWrBusIf.sink                                                   wrBus,
  input  coreFrontEndPkg::regIdxT [coreFrontEndPkg::RD_PORT_NUM-1:0] rs,
  output coreFrontEndPkg::xlenT  [coreFrontEndPkg::RD_PORT_NUM-1:0] rsDat,
  output logic                   [coreFrontEndPkg::RD_PORT_NUM-1:0] datHazard
);
  import coreFrontEndPkg::*;

  //////////////////////////////////////////////////////////////////////
  // Storage and write decode
  //////////////////////////////////////////////////////////////////////

  // x1 to x31 only
  xlenT regQ [1:REG_NUM-1];

  // One-hot write select, gated by the strobe
  logic [REG_NUM-1:0] wrEnOh;

  assign wrEnOh = {REG_NUM{wrBus.wrVld}} & (REG_NUM'(1) << wrBus.wrRd);

  // Bit 0 of wrEnOh has no register behind it
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < REG_NUM; i++) begin
        regQ[i] <= '0;
      end
    end else begin
      for (int i = 1; i < REG_NUM; i++) begin
        if (wrEnOh[i]) begin
          regQ[i] <= wrBus.wrDat;
        end
      end
    end
  end

  // Full read view with x0 tied low
  xlenT rfView [REG_NUM];

  always_comb begin
    rfView[0] = '0;
    for (int i = 1; i < REG_NUM; i++) begin
      rfView[i] = regQ[i];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////////////////////////

  for (genvar p = 0; p < RD_PORT_NUM; p++) begin : gRdPort
    fwdMux fwdMux_inst (
      .fwdVld (wrBus.fwdVld),
      .fwdRd  (wrBus.fwdRd),
      .fwdDat (wrBus.fwdDat),
      .rs     (rs[p]),
      .rfDat  (rfView[rs[p]]),
      .dat    (rsDat[p]),
      .hazard (datHazard[p])
    );
  end

endmodule : regFile

//--- hw/coreFrontEnd.sv
`timescale 1ns/100ps

module coreFrontEnd (
  input  logic                                                        clk,
  input  logic                                                        rstN,
  input  logic                                                        stall,

  // PC redirect and step
  input  logic                    [coreFrontEndPkg::SET_PORT_NUM-1:0] setEn,
  input  coreFrontEndPkg::xlenT   [coreFrontEndPkg::SET_PORT_NUM-1:0] setPc,
  input  coreFrontEndPkg::pcStepT                                     nxtPcStep,
  output coreFrontEndPkg::xlenT                                       pc,
  output coreFrontEndPkg::xlenT                                       nxtPc,

  // Register write port
  input  logic                                                        wrVld,
  input  coreFrontEndPkg::regIdxT                                     wrRd,
  input  coreFrontEndPkg::xlenT                                       wrDat,

  // Results still in the pipe
  input  logic                    [coreFrontEndPkg::FWD_PORT_NUM-1:0] fwdVld,
  input  coreFrontEndPkg::regIdxT [coreFrontEndPkg::FWD_PORT_NUM-1:0] fwdRd,
  input  coreFrontEndPkg::xlenT   [coreFrontEndPkg::FWD_PORT_NUM-1:0] fwdDat,

  // Read ports
  input  coreFrontEndPkg::regIdxT [coreFrontEndPkg::RD_PORT_NUM-1:0]  rs,
  output coreFrontEndPkg::xlenT   [coreFrontEndPkg::RD_PORT_NUM-1:0]  rsDat,
  output logic                    [coreFrontEndPkg::RD_PORT_NUM-1:0]  datHazard
);
  import coreFrontEndPkg::*;

  //////////////////////////////////////////////////////////////////////
  // PC generation
  //////////////////////////////////////////////////////////////////////

  pcGen pcGen_inst (
    .clk       (clk),
    .rstN      (rstN),
    .stall     (stall),
    .setEn     (setEn),
    .setPc     (setPc),
    .nxtPcStep (nxtPcStep),
    .pc        (pc),
    .nxtPc     (nxtPc)
  );

  //////////////////////////////////////////////////////////////////////
  // Write and forwarding bundle
  //////////////////////////////////////////////////////////////////////

  rfWrBusIf wrBus ();

  // Write port
  assign wrBus.wrVld = wrVld;
  assign wrBus.wrRd  = wrRd;
  assign wrBus.wrDat = wrDat;

  // Forwarding buses
  assign wrBus.fwdVld = fwdVld;
  assign wrBus.fwdRd  = fwdRd;
  assign wrBus.fwdDat = fwdDat;

  //////////////////////////////////////////////////////////////////////
  // Register file with forwarding
  //////////////////////////////////////////////////////////////////////

  regFile regFile_inst (
    .clk       (clk),
    .rstN      (rstN),
    .wrBus     (wrBus.sink),
    .rs        (rs),
    .rsDat     (rsDat),
    .datHazard (datHazard)
  );

endmodule : coreFrontEnd

//--- include/coreFrontEndRef.svh
`ifndef CORE_FRONT_END_REF_SVH
`define CORE_FRONT_END_REF_SVH

// Expected next PC, rstFlg low means settling cycle
function automatic coreFrontEndPkg::xlenT refNxtPc(
  input coreFrontEndPkg::xlenT                                       pc,
  input logic                                                        rstFlg,
  input logic                   [coreFrontEndPkg::SET_PORT_NUM-1:0] setEn,
  input coreFrontEndPkg::xlenT  [coreFrontEndPkg::SET_PORT_NUM-1:0] setPc,
  input coreFrontEndPkg::pcStepT                                     step
);
  coreFrontEndPkg::xlenT nxt;
  if (!rstFlg) begin
    return pc;
  end
  nxt = pc + coreFrontEndPkg::xlenT'(step);
  // Walk down so the lowest enabled channel is left standing
  for (int i = coreFrontEndPkg::SET_PORT_NUM - 1; i >= 0; i--) begin
    if (setEn[i]) begin
      nxt = setPc[i];
    end
  end
  return nxt;
endfunction

// Expected read data, rfDat is the shadow register value
function automatic coreFrontEndPkg::xlenT refRsDat(
  input coreFrontEndPkg::regIdxT                                     rs,
  input coreFrontEndPkg::xlenT                                       rfDat,
  input coreFrontEndPkg::regIdxT [coreFrontEndPkg::FWD_PORT_NUM-1:0] fwdRd,
  input coreFrontEndPkg::xlenT   [coreFrontEndPkg::FWD_PORT_NUM-1:0] fwdDat
);
  coreFrontEndPkg::xlenT dat;
  if (rs == '0) begin
    return '0;
  end
  dat = rfDat;
  for (int i = coreFrontEndPkg::FWD_PORT_NUM - 1; i >= 0; i--) begin
    if (fwdRd[i] == rs) begin
      dat = fwdDat[i];
    end
  end
  return dat;
endfunction

// Expected hazard, pending result on the winning bus
function automatic logic refHazard(
  input coreFrontEndPkg::regIdxT                                     rs,
  input logic                    [coreFrontEndPkg::FWD_PORT_NUM-1:0] fwdVld,
  input coreFrontEndPkg::regIdxT [coreFrontEndPkg::FWD_PORT_NUM-1:0] fwdRd
);
  logic hz;
  hz = 1'b0;
  for (int i = coreFrontEndPkg::FWD_PORT_NUM - 1; i >= 0; i--) begin
    if ((rs != '0) && (fwdRd[i] == rs)) begin
      hz = ~fwdVld[i];
    end
  end
  return hz;
endfunction

`endif

//--- testbench/coreFrontEndTb.sv
`timescale 1ns/100ps

module coreFrontEndTb;
  import coreFrontEndPkg::*;

  `include "coreFrontEndRef.svh"

  // Run constants
  localparam logic [31:0] SEED    = 32'ha0e3356e;
  localparam int          CYC_NUM = 60;
  localparam int          TIMEOUT = 100;

  logic                      clk = 1'b0;
  logic                      rstN;
  logic                      stall;
  logic [SET_PORT_NUM-1:0]   setEn;
  xlenT [SET_PORT_NUM-1:0]   setPc;
  pcStepT                    nxtPcStep;
  xlenT                      pc;
  xlenT                      nxtPc;
  logic                      wrVld;
  regIdxT                    wrRd;
  xlenT                      wrDat;
  logic [FWD_PORT_NUM-1:0]   fwdVld;
  regIdxT [FWD_PORT_NUM-1:0] fwdRd;
  xlenT [FWD_PORT_NUM-1:0]   fwdDat;
  regIdxT [RD_PORT_NUM-1:0]  rs;
  xlenT [RD_PORT_NUM-1:0]    rsDat;
  logic [RD_PORT_NUM-1:0]    datHazard;

  // Shadow state
  xlenT shadowReg [REG_NUM];
  xlenT shadowPc;
  logic shadowFlg;

  int errCnt;
  int toCnt;
  int chkCnt;

  coreFrontEnd coreFrontEnd_inst (
    .clk       (clk),
    .rstN      (rstN),
    .stall     (stall),
    .setEn     (setEn),
    .setPc     (setPc),
    .nxtPcStep (nxtPcStep),
    .pc        (pc),
    .nxtPc     (nxtPc),
    .wrVld     (wrVld),
    .wrRd      (wrRd),
    .wrDat     (wrDat),
    .fwdVld    (fwdVld),
    .fwdRd     (fwdRd),
    .fwdDat    (fwdDat),
    .rs        (rs),
    .rsDat     (rsDat),
    .datHazard (datHazard)
  );

  // 40 ns clock
  always #20 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Check tasks and helpers
  //////////////////////////////////////////////////////////////////////

  task automatic checkPc(input string name, input xlenT exp, input xlenT act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      errCnt++;
    end
  endtask

  task automatic checkDat(input string name, input xlenT exp, input xlenT act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      errCnt++;
    end
  endtask

  task automatic checkHazard(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      errCnt++;
    end
  endtask

  // Even word, as a real fetch target
  function automatic xlenT evenWord();
    return xlenT'($urandom()) & ~xlenT'(1);
  endfunction

  // Compressed or full-size step
  function automatic pcStepT drawStep();
    return ($urandom() % 2) ? pcStepT'(4) : pcStepT'(2);
  endfunction

  task automatic waitRstRelease();
    int n;
    n = 0;
    while ((rstN !== 1'b1) && (n < TIMEOUT)) begin
      @(negedge clk);
      n++;
    end
    if (rstN !== 1'b1) begin
      $display("Timeout while waiting for the reset to be released");
      toCnt++;
    end
  endtask

  // Ends on a rising edge once the compare process has caught up
  task automatic waitCheckDone(input string phase);
    int start;
    int n;
    start = chkCnt;
    n = 0;
    while ((chkCnt == start) && (n < TIMEOUT)) begin
      @(posedge clk);
      n++;
    end
    if (chkCnt == start) begin
      $display("Timeout at the end of the %s phase, no compare was done", phase);
      toCnt++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Shadow model and compare
  //////////////////////////////////////////////////////////////////////

  // Sees the same input values as the DUT at the edge
  always @(posedge clk) begin
    if (!rstN) begin
      shadowPc  = START_ADDR;
      shadowFlg = 1'b0;
      for (int i = 0; i < REG_NUM; i++) begin
        shadowReg[i] = '0;
      end
    end else begin
      if (!stall) begin
        shadowPc = refNxtPc(shadowPc, shadowFlg, setEn, setPc, nxtPcStep);
      end
      shadowFlg = 1'b1;
      if (wrVld && (wrRd != '0)) begin
        shadowReg[wrRd] = wrDat;
      end
    end
  end

  // Falling edge, all outputs settled
  always @(negedge clk) begin
    checkPc("pc", shadowPc, pc);
    checkPc("nxtPc", refNxtPc(shadowPc, shadowFlg, setEn, setPc, nxtPcStep), nxtPc);
    for (int p = 0; p < RD_PORT_NUM; p++) begin
      checkDat($sformatf("rsDat[%0d]", p),
               refRsDat(rs[p], shadowReg[rs[p]], fwdRd, fwdDat), rsDat[p]);
      checkHazard($sformatf("datHazard[%0d]", p),
                  refHazard(rs[p], fwdVld, fwdRd), datHazard[p]);
    end
    chkCnt++;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    regIdxT rsNew [RD_PORT_NUM];

    rstN      = 1'b0;
    stall     = 1'b0;
    setEn     = '0;
    setPc     = '0;
    nxtPcStep = pcStepT'(4);
    wrVld     = 1'b0;
    wrRd      = '0;
    wrDat     = '0;
    fwdVld    = '0;
    fwdRd     = '0;
    fwdDat    = '0;
    rs        = '0;
    errCnt    = 0;
    toCnt     = 0;
    chkCnt    = 0;
    void'($urandom(SEED));

    // Redirect and step held through reset and the settling edge
    repeat (4) begin
      @(posedge clk);
      setEn    <= SET_PORT_NUM'(1);
      setPc[0] <= 32'h0000_1000;
    end
    rstN <= 1'b1;
    waitRstRelease();

    // Plain stepping by 4, then by 2
    @(posedge clk);
    setEn <= '0;
    repeat (6) @(posedge clk);
    nxtPcStep <= pcStepT'(2);
    repeat (4) @(posedge clk);
    waitCheckDone("step");

    // PC holds while stalled
    stall     <= 1'b1;
    nxtPcStep <= pcStepT'(4);
    repeat (4) @(posedge clk);
    stall <= 1'b0;
    repeat (2) @(posedge clk);
    waitCheckDone("stall");

    // Random redirects
    repeat (CYC_NUM) begin
      @(posedge clk);
      setEn <= SET_PORT_NUM'($urandom());
      for (int i = 0; i < SET_PORT_NUM; i++) begin
        setPc[i] <= evenWord();
      end
      nxtPcStep <= drawStep();
      stall     <= (($urandom() % 5) == 0);
    end
    @(posedge clk);
    setEn <= '0;
    stall <= 1'b0;
    waitCheckDone("redirect");

    // Writes with readback, port 0 follows the last write target, port 1 at times
    repeat (CYC_NUM) begin
      @(posedge clk);
      wrVld  <= $urandom() % 2;
      wrRd   <= regIdxT'($urandom());
      wrDat  <= xlenT'($urandom());
      rs[0]  <= wrRd;
      rs[1]  <= ($urandom() % 2) ? wrRd : regIdxT'($urandom());
      fwdRd  <= '0;
      fwdVld <= FWD_PORT_NUM'($urandom());
    end
    waitCheckDone("write");

    // Forwarding buses aimed at the read registers
    repeat (CYC_NUM) begin
      @(posedge clk);
      for (int p = 0; p < RD_PORT_NUM; p++) begin
        rsNew[p] = (($urandom() % 6) == 0) ? '0 : regIdxT'($urandom());
        rs[p]   <= rsNew[p];
      end
      for (int i = 0; i < FWD_PORT_NUM; i++) begin
        case ($urandom() % 3)
          0:       fwdRd[i] <= rsNew[0];
          1:       fwdRd[i] <= rsNew[1];
          default: fwdRd[i] <= regIdxT'($urandom());
        endcase
        fwdDat[i] <= xlenT'($urandom());
      end
      fwdVld <= FWD_PORT_NUM'($urandom());
      wrVld  <= $urandom() % 2;
      wrRd   <= regIdxT'($urandom());
      wrDat  <= xlenT'($urandom());
    end
    waitCheckDone("forwarding");

    $display("Checks %0d, mismatches %0d, timeouts %0d", chkCnt, errCnt, toCnt);
    if ((errCnt == 0) && (toCnt == 0)) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : coreFrontEndTb

//--- coreFrontEnd.f
+incdir+include
hw/coreFrontEndPkg.sv
hw/rfWrBusIf.sv
hw/pcGen.sv
hw/fwdMux.sv
hw/regFile.sv
hw/coreFrontEnd.sv
testbench/coreFrontEndTb.sv

//--- Bender.yml
package:
  name: coreFrontEnd

sources:
  # Package first, then interface, blocks and top level
  - hw/coreFrontEndPkg.sv
  - hw/rfWrBusIf.sv
  - hw/pcGen.sv
  - hw/fwdMux.sv
  - hw/regFile.sv
  - hw/coreFrontEnd.sv

  # Testbench with its reference header
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/coreFrontEndTb.sv
